// ==== rtl/heapPkg.sv ====
//------------------------------------------------
// Array heap package
// Widths, typedefs and the action and error codes
//------------------------------------------------
package heapPkg;

  localparam int arrayCount  = 4;                 // Arrays in the heap
  localparam int arrayLength = 8;                 // Elements per array
  localparam int wordWidth   = 16;                // Bits per element

  typedef logic [1:0]                        arrayId;      // Array number
  typedef logic [2:0]                        elementIndex; // Position in an array
  typedef logic [3:0]                        arraySize;    // Element count, 0 to 8
  typedef logic [wordWidth-1:0]              dataWord;     // One element
  typedef logic [arrayLength*wordWidth-1:0]  arrayRow;     // Whole array, element 0 lowest

  typedef enum logic [4:0] {
    actIdle,                                      // No command
    actAlloc,                                     // Allocate an array
    actFree,                                      // Free an array
    actWrite,                                     // Write an element
    actRead,                                      // Read an element
    actSize,                                      // Current size
    actResize,                                    // Set size from input
    actPush,                                      // Append input
    actPop,                                       // Remove last element
    actLess,                                      // Count below input
    actGreater,                                   // Count above input
    actIndex,                                     // Last match plus 1
    actAdd,                                       // Add, return new
    actAddAfter,                                  // Add, return previous
    actSubtract,                                  // Subtract, return new
    actAnd,                                       // Bitwise and
    actOr,                                        // Bitwise or
    actXor                                        // Bitwise xor
  } heapAction;

  typedef enum logic [2:0] {
    errNone,                                      // Command accepted
    errNotAllocated,                              // Array not live
    errOutOfBounds,                               // Index at or past size
    errFull,                                      // Push on full array
    errEmpty,                                     // Pop on empty array
    errTooLarge,                                  // Resize above length
    errOutOfMemory                                // No array left
  } heapError;

endpackage

// ==== rtl/heapController.sv ====
//------------------------------------------------
// Array heap controller
// Decodes and checks commands, keeps array sizes,
// registers result and error
//------------------------------------------------
`timescale 1ns/1ps

module heapController import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  heapAction   action,
  input  arrayId      array,
  input  elementIndex index,
  input  dataWord     dataIn,
  input  logic        arrayLive,
  input  arrayId      grantedId,
  input  logic        outOfMemory,
  input  dataWord     oldValue,
  input  dataWord     newValue,
  input  arraySize    lessCount,
  input  arraySize    greaterCount,
  input  arraySize    matchPosition,
  output logic        allocRequest,               // Strobe, one cycle
  output logic        freeRequest,                // Strobe, one cycle
  output logic        storeWrite,
  output elementIndex storeIndex,
  output dataWord     storeData,
  output heapAction   storeOp,
  output arraySize    selectedSize,
  output dataWord     result,
  output heapError    error
);

  arraySize sizes [arrayCount];                   // Size table
  heapError fault;                                // Error of this command
  logic     accepted;
  logic     inRange;                              // Index below size
  logic     sizeUpdate;
  arrayId   sizeTarget;
  arraySize sizeValue;
  dataWord  nextResult;

  assign selectedSize = sizes[array];
  assign inRange      = {1'b0, index} < selectedSize;
  assign accepted     = fault == errNone;

  //------------------------------------------------
  // Checks
  //------------------------------------------------
  always_comb begin
    fault = errNone;
    if (action == actAlloc) begin
      if (outOfMemory) fault = errOutOfMemory;    // Stack empty, counter spent
    end else if (action != actIdle && !arrayLive) begin
      fault = errNotAllocated;                    // Never allocated or freed
    end else begin
      case (action)
        actRead, actAdd, actAddAfter, actSubtract, actAnd, actOr, actXor:
          if (!inRange) fault = errOutOfBounds;
        actPush:   if (selectedSize == arraySize'(arrayLength)) fault = errFull;
        actPop:    if (selectedSize == '0) fault = errEmpty;
        actResize: if (dataIn > dataWord'(arrayLength)) fault = errTooLarge;
        default:   fault = errNone;
      endcase
    end
  end

  //------------------------------------------------
  // Strobes and store steering
  //------------------------------------------------
  assign allocRequest = action == actAlloc && accepted;
  assign freeRequest  = action == actFree && accepted;
  assign storeOp      = action;                   // Selects the arithmetic
  assign storeWrite   = accepted && (action inside {actWrite, actPush, actAdd,
                        actAddAfter, actSubtract, actAnd, actOr, actXor});

  always_comb begin
    storeIndex = index;
    if (action == actPush) storeIndex = selectedSize[2:0];        // Next free slot
    if (action == actPop) storeIndex = 3'(selectedSize - 4'd1);   // Last element
  end

  assign storeData = (action == actWrite || action == actPush) ? dataIn : oldValue;

  // Size table update
  always_comb begin
    sizeUpdate = 1'b0;
    sizeTarget = array;
    sizeValue  = selectedSize;
    case (action)
      actAlloc: begin
        sizeUpdate = accepted;
        sizeTarget = grantedId;                   // Fresh array starts empty
        sizeValue  = '0;
      end
      actWrite: begin
        sizeUpdate = accepted && !inRange;        // Grow to cover index
        sizeValue  = {1'b0, index} + 4'd1;
      end
      actPush: begin
        sizeUpdate = accepted;
        sizeValue  = selectedSize + 4'd1;
      end
      actPop: begin
        sizeUpdate = accepted;
        sizeValue  = selectedSize - 4'd1;
      end
      actResize: begin
        sizeUpdate = accepted;
        sizeValue  = arraySize'(dataIn);          // Range checked above
      end
      default: sizeUpdate = 1'b0;
    endcase
  end

  // Result per action, free/resize/push keep the last one
  always_comb begin
    nextResult = result;
    case (action)
      actAlloc:                   nextResult = dataWord'(grantedId);
      actWrite:                   nextResult = newValue;
      actRead, actPop:            nextResult = oldValue;
      actAddAfter:                nextResult = oldValue;  // Value before the add
      actSize:                    nextResult = dataWord'(selectedSize);
      actLess:                    nextResult = dataWord'(lessCount);
      actGreater:                 nextResult = dataWord'(greaterCount);
      actIndex:                   nextResult = dataWord'(matchPosition);
      actAdd, actSubtract, actAnd, actOr, actXor:
                                  nextResult = newValue;
      default:                    nextResult = result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
      error  <= errNone;
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (action != actIdle) begin
      error <= fault;
      if (accepted) result <= nextResult;         // Errors keep old result
      if (sizeUpdate) sizes[sizeTarget] <= sizeValue;
    end
  end

endmodule

// ==== rtl/heapAllocator.sv ====
//------------------------------------------------
// Array heap allocator
// Free stack, fresh counter and live flags
//------------------------------------------------
`timescale 1ns/1ps

module heapAllocator import heapPkg::*; (
  input  logic   clock,
  input  logic   reset,
  input  logic   allocRequest,                    // Take grantedId
  input  logic   freeRequest,                     // Return array
  input  arrayId array,
  output logic   arrayLive,
  output arrayId grantedId,
  output logic   outOfMemory
);

  logic [arrayCount-1:0] live;                    // One flag per array
  arrayId                freeStack [arrayCount];  // Freed arrays, last on top
  logic [2:0]            freeTop;                 // Entries on the stack
  logic [2:0]            freshCount;              // Arrays never handed out yet
  arrayId                topSlot;

  assign topSlot   = arrayId'(freeTop - 3'd1);
  assign arrayLive = live[array];

  // Reuse last freed first, else a fresh one
  assign grantedId   = (freeTop != '0) ? freeStack[topSlot] : arrayId'(freshCount);
  assign outOfMemory = freeTop == '0 && freshCount == 3'(arrayCount);

  //------------------------------------------------
  // Control state
  //------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      live       <= '0;
      freeTop    <= '0;
      freshCount <= '0;
    end else if (allocRequest) begin
      live[grantedId] <= 1'b1;
      if (freeTop != '0) begin
        freeTop <= freeTop - 3'd1;                // Pop
      end else begin
        freshCount <= freshCount + 3'd1;          // Next never used array
      end
    end else if (freeRequest) begin
      live[array] <= 1'b0;                        // Second free now fails
      freeTop     <= freeTop + 3'd1;              // Push
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (freeRequest) begin
      freeStack[freeTop[1:0]] <= array;           // At most 3 entries before a push
    end
  end

endmodule

// ==== rtl/heapStore.sv ====
//------------------------------------------------
// Array heap element store
// Element registers with read-modify-write arithmetic
//------------------------------------------------
`timescale 1ns/1ps

module heapStore import heapPkg::*; (
  input  logic        clock,
  input  logic        storeWrite,                 // Level, this cycle only
  input  arrayId      array,
  input  elementIndex storeIndex,
  input  dataWord     storeData,
  input  heapAction   storeOp,
  input  dataWord     dataIn,
  output dataWord     oldValue,
  output dataWord     newValue,
  output arrayRow     row
);

  dataWord elements [arrayCount][arrayLength];    // All arrays, fixed blocks

  assign oldValue = elements[array][storeIndex];  // Asynchronous read

  //------------------------------------------------
  // Arithmetic, wraps at the word width
  //------------------------------------------------
  always_comb begin
    case (storeOp)
      actAdd:      newValue = oldValue + dataIn;
      actAddAfter: newValue = oldValue + dataIn;  // Caller returns oldValue
      actSubtract: newValue = oldValue - dataIn;
      actAnd:      newValue = oldValue & dataIn;
      actOr:       newValue = oldValue | dataIn;
      actXor:      newValue = oldValue ^ dataIn;
      default:     newValue = storeData;          // Write and push data
    endcase
  end

  // Whole selected array for the search
  always_comb begin
    for (int i = 0; i < arrayLength; i++) begin
      row[i*wordWidth +: wordWidth] = elements[array][i];
    end
  end

  always_ff @(posedge clock) begin
    if (storeWrite) begin
      elements[array][storeIndex] <= newValue;
    end
  end

endmodule

// ==== rtl/heapSearch.sv ====
//------------------------------------------------
// Array heap search
// Less, greater and last match over one array
//------------------------------------------------
`timescale 1ns/1ps

module heapSearch import heapPkg::*; (
  input  arrayRow  row,                           // Selected array
  input  arraySize selectedSize,                  // Elements in use
  input  dataWord  dataIn,                        // Search key
  output arraySize lessCount,
  output arraySize greaterCount,
  output arraySize matchPosition                  // Position plus 1, 0 if none
);

  dataWord element;

  always_comb begin
    lessCount     = '0;
    greaterCount  = '0;
    matchPosition = '0;
    element       = '0;
    for (int i = 0; i < arrayLength; i++) begin
      element = row[i*wordWidth +: wordWidth];
      if (arraySize'(i) < selectedSize) begin     // Only live elements
        if (element < dataIn) begin
          lessCount = lessCount + 4'd1;
        end
        if (element > dataIn) begin
          greaterCount = greaterCount + 4'd1;
        end
        if (element == dataIn) begin
          matchPosition = arraySize'(i + 1);      // Later match wins
        end
      end
    end
  end

endmodule

// ==== rtl/arrayHeap.sv ====
//------------------------------------------------
// Array heap top level
// Wires controller, allocator, store and search
//------------------------------------------------
`timescale 1ns/1ps

module arrayHeap import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  heapAction   action,                     // One command per cycle
  input  arrayId      array,
  input  elementIndex index,
  input  dataWord     dataIn,
  output dataWord     result,                     // Registered, 1 cycle
  output heapError    error
);

  logic        arrayLive;                         // Selected array allocated
  arrayId      grantedId;                         // Next array to hand out
  logic        outOfMemory;
  logic        allocRequest;
  logic        freeRequest;
  logic        storeWrite;
  elementIndex storeIndex;
  dataWord     storeData;
  heapAction   storeOp;
  arraySize    selectedSize;
  dataWord     oldValue;
  dataWord     newValue;
  arrayRow     row;
  arraySize    lessCount;
  arraySize    greaterCount;
  arraySize    matchPosition;

  heapController i_heapController (
    .clock        (clock),
    .reset        (reset),
    .action       (action),
    .array        (array),
    .index        (index),
    .dataIn       (dataIn),
    .arrayLive    (arrayLive),
    .grantedId    (grantedId),
    .outOfMemory  (outOfMemory),
    .oldValue     (oldValue),
    .newValue     (newValue),
    .lessCount    (lessCount),
    .greaterCount (greaterCount),
    .matchPosition(matchPosition),
    .allocRequest (allocRequest),
    .freeRequest  (freeRequest),
    .storeWrite   (storeWrite),
    .storeIndex   (storeIndex),
    .storeData    (storeData),
    .storeOp      (storeOp),
    .selectedSize (selectedSize),
    .result       (result),
    .error        (error)
  );

  heapAllocator i_heapAllocator (
    .clock       (clock),
    .reset       (reset),
    .allocRequest(allocRequest),
    .freeRequest (freeRequest),
    .array       (array),
    .arrayLive   (arrayLive),
    .grantedId   (grantedId),
    .outOfMemory (outOfMemory)
  );

  heapStore i_heapStore (
    .clock     (clock),
    .storeWrite(storeWrite),
    .array     (array),
    .storeIndex(storeIndex),
    .storeData (storeData),
    .storeOp   (storeOp),
    .dataIn    (dataIn),
    .oldValue  (oldValue),
    .newValue  (newValue),
    .row       (row)
  );

  heapSearch i_heapSearch (
    .row          (row),
    .selectedSize (selectedSize),
    .dataIn       (dataIn),
    .lessCount    (lessCount),
    .greaterCount (greaterCount),
    .matchPosition(matchPosition)
  );

endmodule

// ==== tb/heapModel.svh ====
//------------------------------------------------
// Array heap reference model
// Sizes, contents, allocation and expected outputs
//------------------------------------------------
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

int       sizeTable [arrayCount];                 // Elements in use per array
dataWord  contents [arrayCount][arrayLength];     // Mirror of the store
bit       liveFlags [arrayCount];
int       freeStack [$];                          // Last freed on the back
int       freshNext = 0;                          // Next never used array
dataWord  expResult = '0;                         // Reset values
heapError expError = errNone;

// Updates the model for one command
function automatic void applyCommand(heapAction act, int arr, int idx, dataWord data);
  heapError e;
  dataWord  r;
  dataWord  old;
  int       n;
  int       granted;
  int       below;
  int       above;
  int       lastMatch;
  if (act == actIdle) return;                     // Nothing changes
  e         = errNone;
  r         = expResult;
  n         = sizeTable[arr];
  old       = contents[arr][idx];
  below     = 0;
  above     = 0;
  lastMatch = 0;
  // Error checks, first match wins
  if (act == actAlloc) begin
    if (freeStack.size() == 0 && freshNext == arrayCount) e = errOutOfMemory;
  end else if (!liveFlags[arr]) begin
    e = errNotAllocated;
  end else if (act inside {actRead, actAdd, actAddAfter, actSubtract, actAnd, actOr,
                           actXor} && idx >= n) begin
    e = errOutOfBounds;
  end else if (act == actPush && n == arrayLength) begin
    e = errFull;
  end else if (act == actPop && n == 0) begin
    e = errEmpty;
  end else if (act == actResize && int'(data) > arrayLength) begin
    e = errTooLarge;
  end
  expError = e;
  if (e != errNone) return;                       // Result and state held
  case (act)
    actAlloc: begin
      if (freeStack.size() > 0) begin
        granted = freeStack.pop_back();           // Last freed first
      end else begin
        granted = freshNext;
        freshNext++;
      end
      liveFlags[granted] = 1'b1;
      sizeTable[granted] = 0;
      r = dataWord'(granted);
    end
    actFree: begin
      liveFlags[arr] = 1'b0;
      freeStack.push_back(arr);
    end
    actWrite: begin
      contents[arr][idx] = data;
      if (idx >= n) sizeTable[arr] = idx + 1;     // Grow to cover index
      r = data;
    end
    actRead:   r = old;
    actSize:   r = dataWord'(n);
    actResize: sizeTable[arr] = int'(data);
    actPush: begin
      contents[arr][n] = data;
      sizeTable[arr]   = n + 1;
    end
    actPop: begin
      r = contents[arr][n - 1];
      sizeTable[arr] = n - 1;
    end
    actLess, actGreater, actIndex: begin
      for (int i = 0; i < n; i++) begin
        if (contents[arr][i] < data) below++;
        if (contents[arr][i] > data) above++;
        if (contents[arr][i] == data) lastMatch = i + 1;
      end
      if (act == actLess) r = dataWord'(below);
      else if (act == actGreater) r = dataWord'(above);
      else r = dataWord'(lastMatch);
    end
    actAdd: begin
      r = old + data;                             // Wraps at 16 bits
      contents[arr][idx] = r;
    end
    actAddAfter: begin
      contents[arr][idx] = old + data;
      r = old;                                    // Previous value returned
    end
    actSubtract: begin
      r = old - data;
      contents[arr][idx] = r;
    end
    actAnd: begin
      r = old & data;
      contents[arr][idx] = r;
    end
    actOr: begin
      r = old | data;
      contents[arr][idx] = r;
    end
    actXor: begin
      r = old ^ data;
      contents[arr][idx] = r;
    end
    default: r = expResult;
  endcase
  expResult = r;
endfunction

`endif

// ==== tb/arrayHeapTb.sv ====
//------------------------------------------------
// Array heap testbench
// Drives commands and checks result and error
// against the reference model
//------------------------------------------------
`timescale 1ns/1ps

module arrayHeapTb import heapPkg::*; ();

  localparam int cycleLimit = 2000;               // Stimulus is well under 1000

  logic        clock = 1'b0;
  logic        reset;
  heapAction   action;
  arrayId      array;
  elementIndex index;
  dataWord     dataIn;
  dataWord     result;
  heapError    error;
  logic [31:0] seed = 32'h21e4;                   // Xorshift state
  int          cycleCount = 0;

  `include "heapModel.svh"

  arrayHeap i_arrayHeap (
    .clock (clock),
    .reset (reset),
    .action(action),
    .array (array),
    .index (index),
    .dataIn(dataIn),
    .result(result),
    .error (error)
  );

  always #2 clock = ~clock;                       // 4 ns period

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the stimulus did not finish within %0d cycles", cycleLimit);
      stopOnFailure();
    end
  end

  //------------------------------------------------
  // Helpers
  //------------------------------------------------
  function automatic logic [31:0] xorshift(logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic dataWord nextRandom();
    seed = xorshift(seed);
    return seed[15:0];
  endfunction

  task automatic stopOnFailure();
    $display("tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkOutputs();
    assert (error === expError) else begin
      $display("[ERROR] %0t: error is %s, expected %s", $time, error.name(), expError.name());
      stopOnFailure();
    end
    assert (result === expResult) else begin
      $display("[ERROR] %0t: result is %h, expected %h", $time, result, expResult);
      stopOnFailure();
    end
  endtask

  // Drives one command and checks the one before it
  task automatic issue(heapAction act, int arr, int idx, dataWord data);
    @(posedge clock);
    action <= act;
    array  <= arrayId'(arr);
    index  <= elementIndex'(idx);
    dataIn <= data;
    @(negedge clock);                             // Outputs of previous command
    checkOutputs();
    applyCommand(act, arr, idx, data);
  endtask

  //------------------------------------------------
  // Behaviors
  //------------------------------------------------
  task automatic allocateAndReuse();
    repeat (arrayCount) issue(actAlloc, 0, 0, 16'd0);   // 0, 1, 2, 3
    issue(actAlloc, 0, 0, 16'd0);                 // Out of memory
    issue(actFree, 1, 0, 16'd0);
    issue(actFree, 3, 0, 16'd0);
    issue(actAlloc, 0, 0, 16'd0);                 // Gets 3
    issue(actAlloc, 0, 0, 16'd0);                 // Gets 1
  endtask

  // Fills every element and leaves each array empty
  task automatic fillArrays();
    for (int a = 0; a < arrayCount; a++) begin
      for (int i = 0; i < arrayLength; i++) begin
        issue(actWrite, a, i, nextRandom());
      end
      issue(actResize, a, 0, 16'd0);
    end
  endtask

  task automatic writeReadSize();
    issue(actWrite, 0, 5, nextRandom());          // Size becomes 6
    issue(actSize, 0, 0, 16'd0);
    issue(actRead, 0, 6, 16'd0);                  // Out of bounds
    issue(actIdle, 3, 7, 16'hffff);               // Error and result held
    issue(actWrite, 0, 2, nextRandom());
    issue(actRead, 0, 2, 16'd0);                  // Back-to-back
    issue(actIdle, 0, 0, 16'd0);
  endtask

  task automatic pushPopResize();
    repeat (arrayLength) issue(actPush, 1, 0, nextRandom());
    issue(actPush, 1, 0, nextRandom());           // Full
    repeat (arrayLength) issue(actPop, 1, 0, 16'd0);    // Reverse order
    issue(actPop, 1, 0, 16'd0);                   // Empty
    issue(actResize, 1, 0, 16'd9);                // Too large
    issue(actResize, 1, 0, 16'd8);
    issue(actSize, 1, 0, 16'd0);
  endtask

  task automatic searchArray();
    dataWord key;
    for (int i = 0; i < arrayLength; i++) begin
      issue(actWrite, 2, i, nextRandom() & 16'h0007);   // Small values for many matches
    end
    for (int k = 0; k < 16; k++) begin
      key = (k % 4 == 3) ? 16'h0008 : (nextRandom() & 16'h0007);
      issue(actResize, 2, 0, nextRandom() % 16'd9);
      issue(actLess, 2, 0, key);
      issue(actGreater, 2, 0, key);
      issue(actIndex, 2, 0, key);                 // 0 when key is 8
    end
  endtask

  task automatic modifyElements();
    heapAction arithOps [6];
    int        slot;
    arithOps = '{actAdd, actAddAfter, actSubtract, actAnd, actOr, actXor};
    for (int i = 0; i < arrayLength; i++) begin
      issue(actWrite, 3, i, nextRandom());
    end
    issue(actWrite, 3, 0, 16'hfff0);
    issue(actAdd, 3, 0, 16'h0020);                // Wraps upward
    issue(actSubtract, 3, 0, 16'h0030);           // Wraps below zero
    issue(actAddAfter, 3, 0, 16'hffff);
    issue(actRead, 3, 0, 16'd0);
    for (int k = 0; k < 8; k++) begin
      for (int j = 0; j < 6; j++) begin
        slot = int'(nextRandom() % 16'd8);
        issue(arithOps[j], 3, slot, nextRandom());
        issue(actRead, 3, slot, 16'd0);           // Stored value
      end
    end
    issue(actResize, 3, 0, 16'd3);
    issue(actAdd, 3, 5, 16'd1);                   // Out of bounds
    issue(actRead, 3, 3, 16'd0);
  endtask

  task automatic useFreedArray();
    issue(actRead, 0, 2, 16'd0);                  // Known result
    issue(actFree, 0, 0, 16'd0);
    issue(actRead, 0, 5, 16'd0);                  // Not allocated and result held
    issue(actWrite, 0, 1, 16'h1234);
    issue(actFree, 0, 0, 16'd0);                  // Second free
    issue(actAlloc, 0, 0, 16'd0);                 // Reuses array 0
    issue(actSize, 0, 0, 16'd0);
  endtask

  //------------------------------------------------
  // Sequence
  //------------------------------------------------
  initial begin
    reset  <= 1'b1;
    action <= actIdle;
    array  <= '0;
    index  <= '0;
    dataIn <= '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    allocateAndReuse();
    fillArrays();
    writeReadSize();
    pushPopResize();
    searchArray();
    modifyElements();
    useFreedArray();
    issue(actIdle, 0, 0, 16'd0);                  // Checks the last command
    issue(actIdle, 0, 0, 16'd0);
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+tb
rtl/heapPkg.sv
rtl/heapController.sv
rtl/heapAllocator.sv
rtl/heapStore.sv
rtl/heapSearch.sv
rtl/arrayHeap.sv
tb/arrayHeapTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the array heap testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module arrayHeapTb -o simArrayHeap
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simArrayHeap 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
